// ==== cnn_pkg.sv ====
package cnn_pkg;

	localparam int data_width = 16; // pixels, weights and biases.
	localparam int acc_width = 2 * data_width + 4; // product plus nine-tap growth.

	// layer defaults, overridden from the top level.
	localparam int default_ifm_size = 5;
	localparam int default_kernel_size = 3;
	localparam int default_number_of_filters = 2;
	localparam int default_number_of_units = 3;

	typedef enum logic [1:0]
	{
		IDLE, // wait for start.
		LOAD, // fetch bias and kernel weights.
		STREAM, // accept pixels.
		DRAIN // let the pipeline empty.
	} conv_state_t;

endpackage

// ==== conv_controller.sv ====
`timescale 1ns/100ps

module conv_controller #(
	parameter int ifm_size = cnn_pkg::default_ifm_size,
	parameter int kernel_size = cnn_pkg::default_kernel_size,
	parameter int number_of_filters = cnn_pkg::default_number_of_filters,
	localparam int taps = kernel_size * kernel_size,
	localparam int load_cycles = 2 * taps + 1,
	localparam int pixel_total = ifm_size * ifm_size,
	localparam int drain_cycles = 4,
	localparam int wm_depth = taps * number_of_filters,
	localparam int wm_address_width = (wm_depth > 1) ? $clog2(wm_depth) : 1,
	localparam int bm_address_width = (number_of_filters > 1) ? $clog2(number_of_filters) : 1,
	localparam int load_width = $clog2(load_cycles),
	localparam int pixel_width = $clog2(pixel_total),
	localparam int position_width = $clog2(ifm_size + 1),
	localparam int drain_width = $clog2(drain_cycles)
)(
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic [bm_address_width-1:0] filter_index,
	input logic pixel_valid,
	output logic busy,
	output logic ready,
	output logic wm_read_enable,
	output logic [wm_address_width-1:0] wm_read_address,
	output logic wm_shift,
	output logic bm_read_enable,
	output logic [bm_address_width-1:0] bm_read_address,
	output logic window_valid
);

	cnn_pkg::conv_state_t state;
	logic [bm_address_width-1:0] filter_reg;
	logic [load_width-1:0] load_count;
	logic [pixel_width-1:0] pixel_count;
	logic [drain_width-1:0] drain_count;
	logic [position_width-1:0] row;
	logic [position_width-1:0] col;
	logic accepted;

	assign busy = state != cnn_pkg::IDLE;
	assign ready = state == cnn_pkg::STREAM;
	assign accepted = ready && pixel_valid;

	// cycle 0 fetches the bias, then odd cycles read and even cycles shift.
	assign bm_read_enable = state == cnn_pkg::LOAD && load_count == '0;
	assign bm_read_address = filter_reg;
	assign wm_read_enable = state == cnn_pkg::LOAD && load_count[0];
	assign wm_shift = state == cnn_pkg::LOAD && load_count != '0 && !load_count[0];
	assign wm_read_address = wm_address_width'(filter_reg * taps)
		+ wm_address_width'(load_count >> 1);

	assign window_valid = accepted
		&& row >= position_width'(kernel_size - 1)
		&& col >= position_width'(kernel_size - 1);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= cnn_pkg::IDLE;
			filter_reg <= '0;
			load_count <= '0;
			pixel_count <= '0;
			drain_count <= '0;
			row <= '0;
			col <= '0;
		end
		else
		begin
			case (state)
				cnn_pkg::IDLE:
				begin
					if (start)
					begin
						state <= cnn_pkg::LOAD;
						filter_reg <= filter_index;
						load_count <= '0;
					end
				end
				cnn_pkg::LOAD:
				begin
					if (load_count == load_width'(load_cycles - 1))
					begin
						state <= cnn_pkg::STREAM;
						pixel_count <= '0;
						row <= '0;
						col <= '0;
					end
					else
						load_count <= load_count + 1'b1;
				end
				cnn_pkg::STREAM:
				begin
					if (accepted)
					begin
						pixel_count <= pixel_count + 1'b1;
						if (col == position_width'(ifm_size - 1))
						begin
							col <= '0;
							row <= row + 1'b1;
						end
						else
							col <= col + 1'b1;
						if (pixel_count == pixel_width'(pixel_total - 1))
						begin
							state <= cnn_pkg::DRAIN;
							drain_count <= '0;
						end
					end
				end
				default:
				begin
					if (drain_count == drain_width'(drain_cycles - 1))
						state <= cnn_pkg::IDLE; // last result leaves now.
					else
						drain_count <= drain_count + 1'b1;
				end
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy)
		else $error("start arrived during a run.");

	assert property (@(posedge clk) disable iff (!arst_n) pixel_valid |-> ready)
		else $error("pixel offered while not ready.");

endmodule

// ==== conv_datapath.sv ====
`timescale 1ns/100ps

module conv_datapath #(
	parameter int ifm_size = cnn_pkg::default_ifm_size,
	parameter int kernel_size = cnn_pkg::default_kernel_size,
	parameter int number_of_filters = cnn_pkg::default_number_of_filters,
	parameter int number_of_units = cnn_pkg::default_number_of_units,
	localparam int wm_depth = kernel_size * kernel_size * number_of_filters,
	localparam int wm_address_width = (wm_depth > 1) ? $clog2(wm_depth) : 1,
	localparam int bm_address_width = (number_of_filters > 1) ? $clog2(number_of_filters) : 1
)(
	input logic clk,
	input logic arst_n,
	input logic signed [cnn_pkg::data_width-1:0] host_data,
	input logic [wm_address_width-1:0] host_address,
	input logic [number_of_units-1:0] wm_write,
	input logic bm_write,
	input logic wm_read_enable,
	input logic [wm_address_width-1:0] wm_read_address,
	input logic wm_shift,
	input logic bm_read_enable,
	input logic [bm_address_width-1:0] bm_read_address,
	input logic pixel_valid,
	input logic signed [cnn_pkg::data_width-1:0] pixel_in_1,
	input logic signed [cnn_pkg::data_width-1:0] pixel_in_2,
	input logic signed [cnn_pkg::data_width-1:0] pixel_in_3,
	input logic window_valid,
	output logic signed [cnn_pkg::acc_width-1:0] result,
	output logic result_valid
);

	logic signed [cnn_pkg::data_width-1:0] unit_pixel [number_of_units];
	logic signed [cnn_pkg::acc_width-1:0] unit_sum [number_of_units];
	logic [bm_address_width-1:0] bm_address;
	logic [cnn_pkg::data_width-1:0] bias_data;
	logic signed [cnn_pkg::acc_width-1:0] bias_ext;
	logic signed [cnn_pkg::acc_width-1:0] biased;
	logic signed [cnn_pkg::acc_width-1:0] stage1_sum;
	logic signed [cnn_pkg::acc_width-1:0] stage1_pass;
	logic signed [cnn_pkg::acc_width-1:0] stage2_sum;
	logic [3:0] valid_pipe;

	if (number_of_units != 3)
	begin : g_unit_count_check
		$error("adder tree is built for three units.");
	end

	assign unit_pixel[0] = pixel_in_1;
	assign unit_pixel[1] = pixel_in_2;
	assign unit_pixel[2] = pixel_in_3;

	for (genvar u = 0; u < number_of_units; u++)
	begin : g_unit
		conv_unit #(
			.ifm_size(ifm_size),
			.kernel_size(kernel_size),
			.number_of_filters(number_of_filters)
		) unit (
			.clk(clk),
			.arst_n(arst_n),
			.host_data(host_data),
			.host_address(host_address),
			.wm_write(wm_write[u]),
			.wm_read_enable(wm_read_enable),
			.wm_read_address(wm_read_address),
			.wm_shift(wm_shift),
			.pixel_valid(pixel_valid),
			.pixel_in(unit_pixel[u]),
			.unit_sum(unit_sum[u])
		);
	end

	assign bm_address = bm_read_enable ? bm_read_address : host_address[bm_address_width-1:0];

	conv_memory #(
		.depth(number_of_filters),
		.width(cnn_pkg::data_width)
	) bias_memory (
		.clk(clk),
		.write_enable(bm_write),
		.read_enable(bm_read_enable),
		.address(bm_address),
		.write_data(host_data),
		.read_data(bias_data) // held for the whole run.
	);

	assign bias_ext = {{(cnn_pkg::acc_width - cnn_pkg::data_width){bias_data[cnn_pkg::data_width-1]}},
		bias_data};
	assign biased = stage2_sum + bias_ext;

	always_ff @(posedge clk)
	begin
		stage1_sum <= unit_sum[0] + unit_sum[1];
		stage1_pass <= unit_sum[2]; // keeps unit 3 in step.
		stage2_sum <= stage1_sum + stage1_pass;
		result <= biased[cnn_pkg::acc_width-1] ? '0 : biased; // relu.
	end

	// line buffer, sum, tree 1 and tree 2, then the result register.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid_pipe <= '0;
			result_valid <= 1'b0;
		end
		else
		begin
			valid_pipe <= {valid_pipe[2:0], window_valid};
			result_valid <= valid_pipe[3];
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		bm_read_enable |-> valid_pipe == '0)
		else $error("bias fetched while results are in flight.");

endmodule

// ==== conv_layer_tb.sv ====
`timescale 1ns/100ps

module conv_layer_tb;

	localparam int ifm_size = cnn_pkg::default_ifm_size;
	localparam int kernel_size = cnn_pkg::default_kernel_size;
	localparam int number_of_filters = cnn_pkg::default_number_of_filters;
	localparam int number_of_units = cnn_pkg::default_number_of_units;
	localparam int dw = cnn_pkg::data_width;
	localparam int aw = cnn_pkg::acc_width;
	localparam int taps = kernel_size * kernel_size;
	localparam int pixel_total = ifm_size * ifm_size;
	localparam int result_total = (ifm_size - kernel_size + 1) * (ifm_size - kernel_size + 1);
	localparam int load_cycles = 2 * taps + 1;
	localparam int pipe_depth = 4;
	localparam int max_gap = 3;
	localparam int test_words = 1024;
	localparam int drive_delay = 2;
	localparam int wm_depth = taps * number_of_filters;
	localparam int wm_address_width = (wm_depth > 1) ? $clog2(wm_depth) : 1;
	localparam int bm_address_width = (number_of_filters > 1) ? $clog2(number_of_filters) : 1;

	logic clk;
	logic arst_n;
	logic signed [dw-1:0] host_data;
	logic [wm_address_width-1:0] host_address;
	logic [number_of_units-1:0] wm_write;
	logic bm_write;
	logic start;
	logic [bm_address_width-1:0] filter_index;
	logic pixel_valid;
	logic signed [dw-1:0] pixel_in_1;
	logic signed [dw-1:0] pixel_in_2;
	logic signed [dw-1:0] pixel_in_3;
	logic busy;
	logic ready;
	logic signed [aw-1:0] result;
	logic result_valid;

	logic [aw-1:0] tests [test_words];
	logic [aw-1:0] expected_q [$];
	int arrival_q [$]; // cycles at which results must show, no-gap runs only.
	logic [31:0] lfsr_state;
	int cycle;
	int result_count;
	int check_count;
	int error_count;
	int timeout_cycles;

	conv_layer_top UUT (
		.clk(clk),
		.arst_n(arst_n),
		.host_data(host_data),
		.host_address(host_address),
		.wm_write(wm_write),
		.bm_write(bm_write),
		.start(start),
		.filter_index(filter_index),
		.pixel_valid(pixel_valid),
		.pixel_in_1(pixel_in_1),
		.pixel_in_2(pixel_in_2),
		.pixel_in_3(pixel_in_3),
		.busy(busy),
		.ready(ready),
		.result(result),
		.result_valid(result_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle++;
	end

	function automatic logic random_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'h80200003; // x^32 + x^22 + x^2 + x + 1.
		return out;
	endfunction

	task automatic check_value(input string name, input logic [aw-1:0] actual,
		input logic [aw-1:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERROR: %s is %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	// outputs are stable at the falling edge.
	always @(negedge clk)
	begin
		if (arst_n && result_valid)
		begin
			result_count++;
			if (expected_q.size() == 0)
			begin
				error_count++;
				$display("result_valid pulsed with no result left to expect at %0t", $time);
			end
			else
				check_value("result", result, expected_q.pop_front());
			if (arrival_q.size() != 0)
				check_value("result_valid cycle", aw'(cycle), aw'(arrival_q.pop_front()));
		end
	end

	task automatic host_write(input logic [number_of_units-1:0] unit_mask, input logic bias,
		input int address, input logic [aw-1:0] word);
		wm_write = unit_mask;
		bm_write = bias;
		host_address = wm_address_width'(address);
		host_data = word[dw-1:0];
		@(posedge clk);
		#drive_delay;
		wm_write = '0;
		bm_write = 1'b0;
	endtask

	// pos points at the first pixel word of the run record.
	task automatic run_filter(input int pos, input int filter, input bit gaps);
		int wait_count;
		int gap;
		int first_result;
		check_value("busy", aw'(busy), aw'(0));
		check_value("ready", aw'(ready), aw'(0));
		first_result = result_count;
		for (int i = 0; i < result_total; i++)
		begin
			expected_q.push_back(tests[pos + 3 * pixel_total + i]);
		end
		filter_index = bm_address_width'(filter);
		start = 1'b1;
		@(posedge clk);
		#drive_delay;
		start = 1'b0;
		check_value("busy", aw'(busy), aw'(1));
		wait_count = 1;
		while (!ready)
		begin
			@(posedge clk);
			#drive_delay;
			wait_count++;
		end
		check_value("start to ready cycles", aw'(wait_count - 1), aw'(load_cycles));
		for (int p = 0; p < pixel_total; p++)
		begin
			if (gaps)
			begin
				gap = int'(random_bit());
				gap = 2 * gap + int'(random_bit());
				repeat (gap)
				begin
					@(posedge clk);
					#drive_delay;
				end
			end
			pixel_valid = 1'b1;
			pixel_in_1 = tests[pos + 3 * p][dw-1:0];
			pixel_in_2 = tests[pos + 3 * p + 1][dw-1:0];
			pixel_in_3 = tests[pos + 3 * p + 2][dw-1:0];
			if (!gaps && p / ifm_size >= kernel_size - 1 && p % ifm_size >= kernel_size - 1)
				arrival_q.push_back(cycle + 1 + pipe_depth); // sampled at the next edge.
			@(posedge clk);
			#drive_delay;
			pixel_valid = 1'b0;
		end
		wait_count = 1;
		while (busy)
		begin
			@(posedge clk);
			#drive_delay;
			wait_count++;
		end
		check_value("last pixel to idle cycles", aw'(wait_count - 1), aw'(pipe_depth));
		@(posedge clk);
		#drive_delay;
		check_value("results per run", aw'(result_count - first_result), aw'(result_total));
	endtask

	task automatic walk_tests(input bit execute, output int runs, output int writes);
		int pos;
		int kind;
		logic [number_of_units-1:0] unit_mask;
		runs = 0;
		writes = 0;
		pos = 0;
		kind = int'(tests[0]);
		while (kind >= 1 && kind <= 3)
		begin
			if (kind == 1)
			begin
				unit_mask = '0;
				unit_mask[tests[pos + 1][1:0]] = 1'b1;
				for (int t = 0; t < taps; t++)
				begin
					if (execute)
						host_write(unit_mask, 1'b0, int'(tests[pos + 2]) * taps + t,
							tests[pos + 3 + t]);
				end
				writes += taps;
				pos += 3 + taps;
			end
			else if (kind == 2)
			begin
				if (execute)
					host_write('0, 1'b1, int'(tests[pos + 1]), tests[pos + 2]);
				writes++;
				pos += 3;
			end
			else
			begin
				if (execute)
					run_filter(pos + 3, int'(tests[pos + 1]), tests[pos + 2][0]);
				runs++;
				pos += 3 + 3 * pixel_total + result_total;
			end
			kind = (pos < test_words) ? int'(tests[pos]) : 0;
		end
		if (execute && kind != 0)
		begin
			error_count++;
			$display("tests file has an unknown record type %0d at word %0d", kind, pos);
		end
	endtask

	initial
	begin
		int runs;
		int writes;
		arst_n = 1'b0;
		host_data = '0;
		host_address = '0;
		wm_write = '0;
		bm_write = 1'b0;
		start = 1'b0;
		filter_index = '0;
		pixel_valid = 1'b0;
		pixel_in_1 = '0;
		pixel_in_2 = '0;
		pixel_in_3 = '0;
		check_count = 0;
		error_count = 0;
		result_count = 0;
		lfsr_state = 32'hbc61f231;
		$readmemh("conv_layer_tests.txt", tests);
		walk_tests(1'b0, runs, writes);
		timeout_cycles = 10 + writes + 50
			+ runs * (load_cycles + 2 + pixel_total * (max_gap + 1) + pipe_depth + 2);
		if (runs == 0)
		begin
			error_count++;
			$display("no run records found in the tests file");
		end
		repeat (10) @(posedge clk);
		#drive_delay;
		arst_n = 1'b1;
		check_value("busy", aw'(busy), aw'(0));
		check_value("ready", aw'(ready), aw'(0));
		check_value("result_valid", aw'(result_valid), aw'(0));
		check_value("controller state", aw'(UUT.u_controller.state), aw'(cnn_pkg::IDLE));
		walk_tests(1'b1, runs, writes);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial
	begin
		cnn_pkg::conv_state_t hung_state;
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge clk);
		hung_state = UUT.u_controller.state;
		$display("run hung: no end after %0d cycles, controller state %s",
			timeout_cycles, hung_state.name());
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== conv_layer_tests.txt ====
// records in hex: 1 unit filter w00..w22 | 2 filter bias | 0 ends the file
// 3 filter gaps, then 25 pixels as ch1 ch2 ch3, then 9 expected results in raster order
1 0 0  1 0 0 0 0 0 0 0 0
1 1 0  0 0 0 0 0 0 0 0 2
1 2 0  1 1 1 1 1 1 1 1 1
1 0 1  ffff ffff ffff ffff ffff ffff ffff ffff ffff
1 1 1  0 0 0 0 fffe 0 0 0 0
1 2 1  0 0 fffd 0 0 0 0 0 0
2 0 5
2 1 10
// filter 0 without gaps
3 0 0
00 0 1  01 1 1  02 2 1  03 3 1  04 4 1
10 1 1  11 2 1  12 3 1  13 4 1  14 5 1
20 2 1  21 3 1  22 4 1  23 5 1  24 6 1
30 3 1  31 4 1  32 5 1  33 6 1  34 7 1
40 4 1  41 5 1  42 6 1  43 7 1  44 8 1
16 19 1c 28 2b 2e 3a 3d 40
// filter 1 sums are negative, relu gives zero
3 1 1
00 0 1  01 1 1  02 2 1  03 3 1  04 4 1
10 1 1  11 2 1  12 3 1  13 4 1  14 5 1
20 2 1  21 3 1  22 4 1  23 5 1  24 6 1
30 3 1  31 4 1  32 5 1  33 6 1  34 7 1
40 4 1  41 5 1  42 6 1  43 7 1  44 8 1
0 0 0 0 0 0 0 0 0
// large bias on filter 1
2 1 1000
3 1 1
00 0 1  01 1 1  02 2 1  03 3 1  04 4 1
10 1 1  11 2 1  12 3 1  13 4 1  14 5 1
20 2 1  21 3 1  22 4 1  23 5 1  24 6 1
30 3 1  31 4 1  32 5 1  33 6 1  34 7 1
40 4 1  41 5 1  42 6 1  43 7 1  44 8 1
f60 f55 f4a ece ec3 eb8 e3c e31 e26
0

// ==== conv_layer_top.sv ====
`timescale 1ns/100ps

module conv_layer_top #(
	parameter int ifm_size = cnn_pkg::default_ifm_size,
	parameter int kernel_size = cnn_pkg::default_kernel_size,
	parameter int number_of_filters = cnn_pkg::default_number_of_filters,
	parameter int number_of_units = cnn_pkg::default_number_of_units,
	localparam int wm_depth = kernel_size * kernel_size * number_of_filters,
	localparam int wm_address_width = (wm_depth > 1) ? $clog2(wm_depth) : 1,
	localparam int bm_address_width = (number_of_filters > 1) ? $clog2(number_of_filters) : 1
)(
	input logic clk,
	input logic arst_n,
	input logic signed [cnn_pkg::data_width-1:0] host_data,
	input logic [wm_address_width-1:0] host_address,
	input logic [number_of_units-1:0] wm_write,
	input logic bm_write,
	input logic start,
	input logic [bm_address_width-1:0] filter_index,
	input logic pixel_valid,
	input logic signed [cnn_pkg::data_width-1:0] pixel_in_1,
	input logic signed [cnn_pkg::data_width-1:0] pixel_in_2,
	input logic signed [cnn_pkg::data_width-1:0] pixel_in_3,
	output logic busy,
	output logic ready,
	output logic signed [cnn_pkg::acc_width-1:0] result,
	output logic result_valid
);

	logic wm_read_enable;
	logic [wm_address_width-1:0] wm_read_address;
	logic wm_shift;
	logic bm_read_enable;
	logic [bm_address_width-1:0] bm_read_address;
	logic window_valid;

	conv_controller #(
		.ifm_size(ifm_size),
		.kernel_size(kernel_size),
		.number_of_filters(number_of_filters)
	) u_controller (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.filter_index(filter_index),
		.pixel_valid(pixel_valid),
		.busy(busy),
		.ready(ready),
		.wm_read_enable(wm_read_enable),
		.wm_read_address(wm_read_address),
		.wm_shift(wm_shift),
		.bm_read_enable(bm_read_enable),
		.bm_read_address(bm_read_address),
		.window_valid(window_valid)
	);

	conv_datapath #(
		.ifm_size(ifm_size),
		.kernel_size(kernel_size),
		.number_of_filters(number_of_filters),
		.number_of_units(number_of_units)
	) u_datapath (
		.clk(clk),
		.arst_n(arst_n),
		.host_data(host_data),
		.host_address(host_address),
		.wm_write(wm_write),
		.bm_write(bm_write),
		.wm_read_enable(wm_read_enable),
		.wm_read_address(wm_read_address),
		.wm_shift(wm_shift),
		.bm_read_enable(bm_read_enable),
		.bm_read_address(bm_read_address),
		.pixel_valid(pixel_valid),
		.pixel_in_1(pixel_in_1),
		.pixel_in_2(pixel_in_2),
		.pixel_in_3(pixel_in_3),
		.window_valid(window_valid),
		.result(result),
		.result_valid(result_valid)
	);

endmodule

// ==== conv_memory.sv ====
`timescale 1ns/100ps

module conv_memory #(
	parameter int depth = 18,
	parameter int width = 16,
	localparam int address_width = (depth > 1) ? $clog2(depth) : 1
)(
	input logic clk,
	input logic write_enable,
	input logic read_enable,
	input logic [address_width-1:0] address,
	input logic [width-1:0] write_data,
	output logic [width-1:0] read_data
);

	logic [width-1:0] storage [depth];

	always_ff @(posedge clk)
	begin
		if (write_enable)
			storage[address] <= write_data;
		if (read_enable)
			read_data <= storage[address]; // holds otherwise.
	end

	// host and controller never share the port in one cycle.
	assert property (@(posedge clk) !(write_enable && read_enable))
		else $error("memory written and read in the same cycle.");

endmodule

// ==== conv_unit.sv ====
`timescale 1ns/100ps

module conv_unit #(
	parameter int ifm_size = cnn_pkg::default_ifm_size,
	parameter int kernel_size = cnn_pkg::default_kernel_size,
	parameter int number_of_filters = cnn_pkg::default_number_of_filters,
	localparam int taps = kernel_size * kernel_size,
	localparam int wm_depth = taps * number_of_filters,
	localparam int wm_address_width = (wm_depth > 1) ? $clog2(wm_depth) : 1,
	localparam int fifo_size = (kernel_size - 1) * ifm_size + kernel_size
)(
	input logic clk,
	input logic arst_n,
	input logic signed [cnn_pkg::data_width-1:0] host_data,
	input logic [wm_address_width-1:0] host_address,
	input logic wm_write,
	input logic wm_read_enable,
	input logic [wm_address_width-1:0] wm_read_address,
	input logic wm_shift,
	input logic pixel_valid,
	input logic signed [cnn_pkg::data_width-1:0] pixel_in,
	output logic signed [cnn_pkg::acc_width-1:0] unit_sum
);

	logic [wm_address_width-1:0] wm_address;
	logic [cnn_pkg::data_width-1:0] wm_data;
	logic signed [cnn_pkg::data_width-1:0] line_buffer [fifo_size];
	logic signed [cnn_pkg::data_width-1:0] kernel_window [taps];
	logic signed [cnn_pkg::acc_width-1:0] window_sum;

	assign wm_address = wm_read_enable ? wm_read_address : host_address;

	conv_memory #(
		.depth(wm_depth),
		.width(cnn_pkg::data_width)
	) weight_memory (
		.clk(clk),
		.write_enable(wm_write),
		.read_enable(wm_read_enable),
		.address(wm_address),
		.write_data(host_data),
		.read_data(wm_data)
	);

	// newest pixel at index 0.
	always_ff @(posedge clk)
	begin
		if (pixel_valid)
		begin
			line_buffer[0] <= pixel_in;
			for (int i = 1; i < fifo_size; i++)
			begin
				line_buffer[i] <= line_buffer[i-1];
			end
		end
	end

	// weights arrive in row-major order, last tap ends at index 0.
	always_ff @(posedge clk)
	begin
		if (wm_shift)
		begin
			kernel_window[0] <= $signed(wm_data);
			for (int i = 1; i < taps; i++)
			begin
				kernel_window[i] <= kernel_window[i-1];
			end
		end
	end

	// tap (r, c) of the window sits (k-1-r) rows and (k-1-c) columns back.
	always_comb
	begin
		window_sum = '0;
		for (int r = 0; r < kernel_size; r++)
		begin
			for (int c = 0; c < kernel_size; c++)
			begin
				window_sum = window_sum
					+ line_buffer[(kernel_size - 1 - r) * ifm_size + kernel_size - 1 - c]
					* kernel_window[taps - 1 - r * kernel_size - c];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			unit_sum <= '0;
		else
			unit_sum <= window_sum; // pipeline stage 1.
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the conv layer testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f verilog.f --top-module conv_layer_tb -o conv_layer_sim
output=$(./obj_dir/conv_layer_sim || true)
echo "$output"
echo "$output" | grep -qx "Done: no errors"

// ==== verilog.f ====
cnn_pkg.sv
conv_memory.sv
conv_unit.sv
conv_datapath.sv
conv_controller.sv
conv_layer_top.sv
conv_layer_tb.sv
